/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_sorter
FILELIST  := sources.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

/* sim/sorter_checker.sv */
// Result stream checker. It follows every accepted result beat, compares it
// with the frame table of the testbench and prints one line per frame.

`timescale 1ns/1ps

module sorter_checker #(
    parameter int NUM_FRAMES      = 7,
    parameter int MAX_VALUES      = 20,
    parameter int MAX_SORT_LENGTH = 16
) (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              res_valid,
    input  logic                              res_ready,
    input  sorter_pkg::result_beat_t          res_beat,
    input  logic [sorter_pkg::DATA_WIDTH-1:0] frame_values [NUM_FRAMES][MAX_VALUES],
    input  int                                frame_len [NUM_FRAMES],
    input  int                                exp_index [NUM_FRAMES][MAX_SORT_LENGTH],
    output int                                frames_done,
    output int                                frames_passed,
    output int                                error_count
);

    int frame;
    int beat;
    bit frame_ok;

    // Frames longer than the limit are cut to the limit
    function automatic int expected_beats(input int f);
        return (frame_len[f] < MAX_SORT_LENGTH) ? frame_len[f] : MAX_SORT_LENGTH;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED frame %0d beat %0d: %s expected 0x%0h, got 0x%0h",
                     frame, beat, name, expected, actual);
            error_count++;
            frame_ok = 1'b0;
        end
    endtask

    // A command marked last returns nothing, so its frame closes at once
    task automatic skip_empty_frames();
        while (frame < NUM_FRAMES && expected_beats(frame) == 0) begin
            $display("frame %0d: empty command, no result expected", frame);
            frames_passed++;
            frames_done++;
            frame++;
        end
    endtask

    task automatic check_beat();
        int n;
        if (frame >= NUM_FRAMES) begin
            $display("Extra result beat after the last frame, value 0x%0h", res_beat.value);
            error_count++;
            return;
        end
        n = expected_beats(frame);
        compare("res_beat.value", 32'(frame_values[frame][exp_index[frame][beat]]),
                32'(res_beat.value));
        compare("res_beat.index", 32'(exp_index[frame][beat]), 32'(res_beat.index));
        compare("res_beat.rank", 32'(beat), 32'(res_beat.rank));
        compare("res_beat.last", 32'(beat == n - 1), 32'(res_beat.last));
        beat++;
        if (beat == n) begin
            $display("frame %0d: %0d beats, %s", frame, n, frame_ok ? "passed" : "failed");
            if (frame_ok) begin
                frames_passed++;
            end
            frames_done++;
            frame++;
            beat     = 0;
            frame_ok = 1'b1;
            skip_empty_frames();
        end
    endtask

    initial begin
        frame         = 0;
        beat          = 0;
        frame_ok      = 1'b1;
        frames_done   = 0;
        frames_passed = 0;
        error_count   = 0;
        skip_empty_frames();
        forever begin
            @(posedge clock);
            if (arst_n && res_valid && res_ready) begin
                check_beat();
            end
        end
    end

endmodule

/* sim/sorter_properties.sv */
// Handshake assertions for the argument and result streams of the sorter top level.
// Attached to sorter_top by a bind in the testbench.

`timescale 1ns/1ps

module sorter_properties (
    input logic                     clock,
    input logic                     arst_n,
    input logic                     arg_valid,
    input logic                     arg_ready,
    input sorter_pkg::arg_beat_t    arg_beat,
    input logic                     res_valid,
    input logic                     res_ready,
    input sorter_pkg::result_beat_t res_beat
);

    // A beat that waits for ready keeps its valid and its payload
    arg_hold: assert property (@(posedge clock) disable iff (!arst_n)
        arg_valid && !arg_ready |=> arg_valid && $stable(arg_beat))
        else $error("Argument beat changed or withdrawn before it was accepted");

    res_hold: assert property (@(posedge clock) disable iff (!arst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_beat))
        else $error("Result beat changed or withdrawn before it was accepted");

    res_quiet_in_reset: assert property (@(posedge clock) !arst_n |-> !res_valid)
        else $error("Result valid raised while reset is active");

endmodule

/* sim/tb_sorter.sv */
// Testbench top for the streaming sorter. It applies a table of frames on the
// argument stream, lets the checker follow the results and prints the verdict.

`timescale 1ns/1ps

module tb_sorter;

    localparam int NUM_FRAMES      = 7;
    localparam int MAX_VALUES      = 20;
    // Matches the frame limit that sorter_top sets
    localparam int MAX_SORT_LENGTH = 16;
    localparam int WAIT_LIMIT      = 2000;

    logic                     clock;
    logic                     arst_n;
    logic                     arg_valid;
    logic                     arg_ready;
    sorter_pkg::arg_beat_t    arg_beat;
    logic                     res_valid;
    logic                     res_ready;
    sorter_pkg::result_beat_t res_beat;
    int                       frames_done;
    int                       frames_passed;
    int                       error_count;
    bit                       stalled;
    bit                       timed_out;
    integer                   seed = 32'hda06;

    // Bit 0 of the command selects descending order; length 0 sends a command marked last
    logic [15:0] frame_cmd [NUM_FRAMES] = '{16'h0, 16'h1, 16'h0, 16'h0, 16'h0, 16'h1, 16'h0};
    int          frame_len [NUM_FRAMES] = '{5, 6, 20, 0, 1, 4, 3};
    logic [sorter_pkg::DATA_WIDTH-1:0] frame_values [NUM_FRAMES][MAX_VALUES] = '{
        '{30, 10, 50, 20, 40, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{5, 9, 5, 7, 9, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{16, 23, 30, 21, 28, 19, 26, 17, 24, 31, 22, 29, 20, 27, 18, 25, 1, 2, 3, 4},
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{1234, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{3, 8, 1, 8, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{4, 4, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
    };
    // Input positions in result order; ties keep their input order in both directions
    int exp_index [NUM_FRAMES][MAX_SORT_LENGTH] = '{
        '{1, 3, 0, 4, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{1, 4, 3, 0, 2, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{0, 7, 14, 5, 12, 3, 10, 1, 8, 15, 6, 13, 4, 11, 2, 9},
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{1, 3, 0, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{0, 1, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
    };

    sorter_top u_dut (
        .clock     (clock),
        .arst_n    (arst_n),
        .arg_valid (arg_valid),
        .arg_ready (arg_ready),
        .arg_beat  (arg_beat),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_beat  (res_beat)
    );

    sorter_checker #(
        .NUM_FRAMES      (NUM_FRAMES),
        .MAX_VALUES      (MAX_VALUES),
        .MAX_SORT_LENGTH (MAX_SORT_LENGTH)
    ) u_checker (
        .clock         (clock),
        .arst_n        (arst_n),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_beat      (res_beat),
        .frame_values  (frame_values),
        .frame_len     (frame_len),
        .exp_index     (exp_index),
        .frames_done   (frames_done),
        .frames_passed (frames_passed),
        .error_count   (error_count)
    );

    bind sorter_top sorter_properties u_properties (
        .clock     (clock),
        .arst_n    (arst_n),
        .arg_valid (arg_valid),
        .arg_ready (arg_ready),
        .arg_beat  (arg_beat),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_beat  (res_beat)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Random back-pressure on the result stream, ready about three cycles in four
    initial begin
        res_ready = 1'b0;
        forever begin
            @(posedge clock);
            res_ready <= ($random(seed) & 3) != 0;
        end
    end

    task automatic send_beat(input logic [sorter_pkg::DATA_WIDTH-1:0] data, input logic last);
        int waited;
        waited = 0;
        arg_valid <= 1'b1;
        arg_beat  <= '{data: data, last: last};
        @(posedge clock);
        while (!arg_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        if (!arg_ready) begin
            $display("Argument stream stalled, arg_ready stayed low for %0d cycles", WAIT_LIMIT);
            stalled = 1'b1;
        end
    endtask

    task automatic send_frame(input int f);
        send_beat(frame_cmd[f], frame_len[f] == 0);
        for (int i = 0; i < frame_len[f] && !stalled; i++) begin
            send_beat(frame_values[f][i], i == frame_len[f] - 1);
        end
    endtask

    initial begin
        int waited;
        arst_n    = 1'b1;
        arg_valid = 1'b0;
        arg_beat  = '0;
        stalled   = 1'b0;
        timed_out = 1'b0;
        waited    = 0;
        #1 arst_n = 1'b0;
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;
        @(posedge clock);
        for (int f = 0; f < NUM_FRAMES && !stalled; f++) begin
            send_frame(f);
        end
        arg_valid <= 1'b0;
        while (frames_done < NUM_FRAMES && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        if (frames_done < NUM_FRAMES) begin
            $display("Timed out waiting for results, %0d of %0d frames done",
                     frames_done, NUM_FRAMES);
            timed_out = 1'b1;
        end
        // A short quiet period so that an extra beat is still seen by the checker
        repeat (20) @(posedge clock);
        $display("Frames passed: %0d, failed: %0d, errors: %0d",
                 frames_passed, NUM_FRAMES - frames_passed, error_count);
        if (stalled || timed_out || error_count != 0 || frames_passed != NUM_FRAMES) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

/* source/efi_sorter.sv */
// Frame controller of the sorter. It decodes the command beat, tags values
// with their input position and turns the drained entries into ranked results.

`timescale 1ns/1ps

module efi_sorter #(
    parameter int MAX_SORT_LENGTH = 16
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     arg_valid,
    output logic                     arg_ready,
    input  sorter_pkg::arg_beat_t    arg_beat,
    output logic                     sort_start,
    output logic                     sort_descending,
    output logic                     ins_valid,
    output sorter_pkg::sort_entry_t  ins_entry,
    output logic                     sort_end,
    input  logic                     drain_valid,
    output logic                     drain_ready,
    input  sorter_pkg::sort_entry_t  drain_entry,
    input  logic                     drain_last,
    output logic                     res_valid,
    input  logic                     res_ready,
    output sorter_pkg::result_beat_t res_beat
);

    localparam int COUNT_WIDTH = $clog2(MAX_SORT_LENGTH + 1);
    localparam int IDX_WIDTH   = sorter_pkg::INDEX_WIDTH;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_FLUSH,
        S_DRAIN
    } state_t;

    state_t                 state;
    logic [COUNT_WIDTH-1:0] value_count;
    logic [IDX_WIDTH-1:0]   rank;
    logic                   arg_take;
    logic                   drain_take;
    logic                   res_take;
    logic                   keep_value;

    assign arg_ready  = (state == S_IDLE) || (state == S_FILL);
    assign arg_take   = arg_valid && arg_ready;
    assign keep_value = value_count < COUNT_WIDTH'(MAX_SORT_LENGTH);
    assign res_take   = res_valid && res_ready;

    // Pull from the engine only when the result register frees up this cycle,
    // and never past the beat marked last
    assign drain_ready = (state == S_DRAIN) &&
                         !(res_valid && (!res_ready || res_beat.last));
    assign drain_take  = drain_valid && drain_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state           <= S_IDLE;
            sort_start      <= 1'b0;
            sort_descending <= 1'b0;
            ins_valid       <= 1'b0;
            sort_end        <= 1'b0;
            value_count     <= '0;
            rank            <= '0;
            res_valid       <= 1'b0;
        end else begin
            sort_start <= 1'b0;
            sort_end   <= 1'b0;
            ins_valid  <= 1'b0;
            case (state)
                S_IDLE: begin
                    // A command marked last is an empty frame and is dropped
                    if (arg_take && !arg_beat.last) begin
                        sort_descending <= arg_beat.data[sorter_pkg::ORDER_BIT];
                        sort_start      <= 1'b1;
                        value_count     <= '0;
                        rank            <= '0;
                        state           <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (arg_take) begin
                        if (keep_value) begin
                            ins_valid   <= 1'b1;
                            value_count <= value_count + 1'b1;
                        end
                        if (arg_beat.last) begin
                            sort_end <= 1'b1;
                            state    <= S_FLUSH;
                        end
                    end
                end
                S_FLUSH: begin
                    state <= S_DRAIN;
                end
                S_DRAIN: begin
                    if (res_take && res_beat.last) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase

            if (drain_take) begin
                res_valid <= 1'b1;
                rank      <= rank + 1'b1;
            end else if (res_take) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_FILL && arg_take) begin
            ins_entry.value <= arg_beat.data;
            ins_entry.index <= IDX_WIDTH'(value_count);
        end
        if (drain_take) begin
            res_beat.value <= drain_entry.value;
            res_beat.index <= drain_entry.index;
            res_beat.rank  <= rank;
            res_beat.last  <= drain_last;
        end
    end

endmodule

/* source/insertion_sort_engine.sv */
// Parallel insertion sorter. Entries are placed in order as they arrive,
// then drained from slot 0 one per cycle.

`timescale 1ns/1ps

module insertion_sort_engine #(
    parameter int MAX_SORT_LENGTH = 16
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    start,
    input  logic                    descending,
    input  logic                    ins_valid,
    input  sorter_pkg::sort_entry_t ins_entry,
    output logic                    ins_ready,
    input  logic                    end_of_input,
    output logic                    drain_valid,
    input  logic                    drain_ready,
    output sorter_pkg::sort_entry_t drain_entry,
    output logic                    drain_last
);

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_FILL,
        ENG_DRAIN
    } eng_state_t;

    eng_state_t                 state;
    logic                       descending_q;
    sorter_pkg::sort_entry_t    slot [MAX_SORT_LENGTH];
    logic [MAX_SORT_LENGTH-1:0] occupied;
    logic [MAX_SORT_LENGTH:0]   occupied_ext;
    logic [MAX_SORT_LENGTH-1:0] goes_before;
    logic                       insert;
    logic                       pop;

    assign ins_ready = state == ENG_FILL;
    assign insert    = ins_valid && ins_ready;

    // Occupied slots are always contiguous from slot 0
    assign drain_valid  = (state == ENG_DRAIN) && occupied[0];
    assign pop          = drain_valid && drain_ready;
    assign drain_entry  = slot[0];
    assign occupied_ext = {1'b0, occupied};
    assign drain_last   = drain_valid && !occupied_ext[1];

    for (genvar i = 0; i < MAX_SORT_LENGTH; i++) begin : g_slot
        sorter_pkg::sort_entry_t from_below;
        sorter_pkg::sort_entry_t from_above;

        // The lowest slot that yields takes the new entry, the slots above it shift up
        if (i == 0) begin : g_bottom
            assign from_below = ins_entry;
        end else begin : g_inner_below
            assign from_below = goes_before[i-1] ? slot[i-1] : ins_entry;
        end

        if (i == MAX_SORT_LENGTH - 1) begin : g_top
            assign from_above = slot[i];
        end else begin : g_inner_above
            assign from_above = slot[i+1];
        end

        // Ties go after the stored entry, so equal values keep input order
        always_comb begin
            if (!occupied[i]) begin
                goes_before[i] = 1'b1;
            end else if (descending_q) begin
                goes_before[i] = ins_entry.value > slot[i].value;
            end else begin
                goes_before[i] = ins_entry.value < slot[i].value;
            end
        end

        always_ff @(posedge clock) begin
            if (insert && goes_before[i]) begin
                slot[i] <= from_below;
            end else if (pop) begin
                slot[i] <= from_above;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            occupied <= '0;
        end else if (start) begin
            occupied <= '0;
        end else if (insert) begin
            occupied <= MAX_SORT_LENGTH'({occupied, 1'b1});
        end else if (pop) begin
            occupied <= occupied >> 1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state        <= ENG_IDLE;
            descending_q <= 1'b0;
        end else if (start) begin
            state        <= ENG_FILL;
            descending_q <= descending;
        end else begin
            case (state)
                ENG_FILL: begin
                    if (end_of_input) begin
                        state <= ENG_DRAIN;
                    end
                end
                ENG_DRAIN: begin
                    if (pop && drain_last) begin
                        state <= ENG_IDLE;
                    end
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/sorter_pkg.sv */
// Shared widths, stream beat types and command encoding for the sort accelerator.
// Every RTL file and the testbench refer to these by scoped names.

package sorter_pkg;

    // Width of one value word
    localparam int DATA_WIDTH = 16;

    // Width of an input position and of a rank, enough for 256 entries
    localparam int INDEX_WIDTH = 8;

    // Bit of the command word that selects descending order
    localparam int ORDER_BIT = 0;

    // One beat of the argument stream, the command word or a value
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } arg_beat_t;

    // A value tagged with its position in the input frame
    typedef struct packed {
        logic [DATA_WIDTH-1:0]  value;
        logic [INDEX_WIDTH-1:0] index;
    } sort_entry_t;

    // One beat of the result stream
    typedef struct packed {
        logic [DATA_WIDTH-1:0]  value;
        logic [INDEX_WIDTH-1:0] index;
        logic [INDEX_WIDTH-1:0] rank;
        logic                   last;
    } result_beat_t;

endpackage

/* source/sorter_top.sv */
// Top level of the streaming sorter: argument FIFO, frame controller,
// insertion engine and result FIFO in a chain.

`timescale 1ns/1ps

module sorter_top #(
    parameter int MAX_SORT_LENGTH = 16,
    parameter int FIFO_DEPTH      = 8
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     arg_valid,
    output logic                     arg_ready,
    input  sorter_pkg::arg_beat_t    arg_beat,
    output logic                     res_valid,
    input  logic                     res_ready,
    output sorter_pkg::result_beat_t res_beat
);

    logic                     ctl_arg_valid;
    logic                     ctl_arg_ready;
    sorter_pkg::arg_beat_t    ctl_arg_beat;
    logic                     sort_start;
    logic                     sort_descending;
    logic                     ins_valid;
    sorter_pkg::sort_entry_t  ins_entry;
    logic                     sort_end;
    logic                     drain_valid;
    logic                     drain_ready;
    sorter_pkg::sort_entry_t  drain_entry;
    logic                     drain_last;
    logic                     ctl_res_valid;
    logic                     ctl_res_ready;
    sorter_pkg::result_beat_t ctl_res_beat;

    stream_fifo #(
        .payload_t  (sorter_pkg::arg_beat_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_arg_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (arg_valid),
        .in_ready  (arg_ready),
        .in_data   (arg_beat),
        .out_valid (ctl_arg_valid),
        .out_ready (ctl_arg_ready),
        .out_data  (ctl_arg_beat)
    );

    efi_sorter #(
        .MAX_SORT_LENGTH (MAX_SORT_LENGTH)
    ) u_efi_sorter (
        .clock           (clock),
        .arst_n          (arst_n),
        .arg_valid       (ctl_arg_valid),
        .arg_ready       (ctl_arg_ready),
        .arg_beat        (ctl_arg_beat),
        .sort_start      (sort_start),
        .sort_descending (sort_descending),
        .ins_valid       (ins_valid),
        .ins_entry       (ins_entry),
        .sort_end        (sort_end),
        .drain_valid     (drain_valid),
        .drain_ready     (drain_ready),
        .drain_entry     (drain_entry),
        .drain_last      (drain_last),
        .res_valid       (ctl_res_valid),
        .res_ready       (ctl_res_ready),
        .res_beat        (ctl_res_beat)
    );

    // The engine is ready for the whole fill phase, so the controller
    // sends its tagged values without waiting on ins_ready
    insertion_sort_engine #(
        .MAX_SORT_LENGTH (MAX_SORT_LENGTH)
    ) u_engine (
        .clock        (clock),
        .arst_n       (arst_n),
        .start        (sort_start),
        .descending   (sort_descending),
        .ins_valid    (ins_valid),
        .ins_entry    (ins_entry),
        .ins_ready    (),
        .end_of_input (sort_end),
        .drain_valid  (drain_valid),
        .drain_ready  (drain_ready),
        .drain_entry  (drain_entry),
        .drain_last   (drain_last)
    );

    stream_fifo #(
        .payload_t  (sorter_pkg::result_beat_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_res_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (ctl_res_valid),
        .in_ready  (ctl_res_ready),
        .in_data   (ctl_res_beat),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (res_beat)
    );

endmodule

/* source/stream_fifo.sv */
// Valid/ready FIFO with a configurable payload type.
// Used for both the argument beats and the result beats of the sorter.

`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    payload_t               storage [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   full;
    logic                   push;
    logic                   pop;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = count == COUNT_WIDTH'(FIFO_DEPTH);
    assign out_valid = count != '0;
    assign out_data  = storage[rd_ptr];

    // A full FIFO still takes a beat in the cycle one leaves
    assign in_ready = !full || out_ready;
    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            storage[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* sources.f */
source/sorter_pkg.sv
source/stream_fifo.sv
source/insertion_sort_engine.sv
source/efi_sorter.sv
source/sorter_top.sv
sim/sorter_properties.sv
sim/sorter_checker.sv
sim/tb_sorter.sv
